/* source/keypad_pkg.sv */
package keypad_pkg;

    // ========================================================================
    // Keypad geometry and timing
    // ========================================================================
    localparam int ROWS = 4;               // Driven lines, active low
    localparam int COLS = 4;               // Sensed lines, pulled up

    localparam int SCAN_PERIOD     = 16;   // Cycles per row, one frame is 64
    localparam int DEBOUNCE_FRAMES = 3;    // Matching single-key frames to accept
    localparam int DIGIT_PERIOD    = 32;   // Cycles each digit stays lit

    // Key index is row * COLS + col
    localparam logic [3:0] KEY_LAYOUT [0:ROWS*COLS-1] = '{
        4'h1, 4'h2, 4'h3, 4'hA,            // Row 0
        4'h4, 4'h5, 4'h6, 4'hB,            // Row 1
        4'h7, 4'h8, 4'h9, 4'hC,            // Row 2
        4'hE, 4'h0, 4'hF, 4'hD             // Row 3
    };

    // ========================================================================
    // Seven-segment encoding, gfedcba, active low
    // ========================================================================
    localparam logic [6:0] SEG_BLANK = 7'b111_1111;   // Every segment dark

    function automatic logic [6:0] seg_of(input logic [3:0] code);
        logic [6:0] lit;                   // Active-high pattern
        case (code)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;             // Lower-case b
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;             // Lower-case d
            4'hE: lit = 7'h79;
            default: lit = 7'h71;          // F
        endcase
        return ~lit;                       // Segments sink current
    endfunction

endpackage

/* source/keypad_scanner.sv */
module keypad_scanner
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,             // Async, active low
    input  logic [3:0]  col,               // Pulled up, low when key closes
    output logic [3:0]  row,               // One row low at a time
    output logic [15:0] key_matrix,        // 1 = pressed, bit = key index
    output logic        frame_done         // One-cycle strobe after row 3
);

    localparam int DWELL_W = $clog2(SCAN_PERIOD);
    localparam int PTR_W   = $clog2(ROWS);

    logic [DWELL_W-1:0]       dwell_cnt;   // Cycles spent on current row
    logic [PTR_W-1:0]         row_ptr;     // Active row
    logic                     row_end;     // Last cycle of dwell
    logic [COLS-1:0]          col_meta;    // Sync stage 1
    logic [COLS-1:0]          col_sync;    // Sync stage 2
    logic [(ROWS-1)*COLS-1:0] frame_buf;   // Rows 0..2 of frame in progress

    // ========================================================================
    // Row sequencing
    // ========================================================================
    assign row_end = (dwell_cnt == DWELL_W'(SCAN_PERIOD - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwell_cnt <= '0;
            row_ptr   <= '0;               // Row 0 drives straight out of reset
        end else if (row_end) begin
            dwell_cnt <= '0;
            row_ptr   <= row_ptr + 1'b1;   // Wraps 3 -> 0
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // Decode to active low
    assign row = ~(4'b0001 << row_ptr);

    // ========================================================================
    // Column synchronizer
    // ========================================================================
    // Two flops, so col_sync lags the pins by two cycles. The last cycle of
    // the dwell still sees columns taken while this row was driven
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_meta <= '1;                // Idle = no key
            col_sync <= '1;
        end else begin
            col_meta <= col;
            col_sync <= col_meta;
        end
    end

    // ========================================================================
    // Matrix capture
    // ========================================================================
    // Rows 0..2 land in a staging buffer
    always_ff @(posedge clk) begin
        if (row_end && (row_ptr != PTR_W'(ROWS - 1))) begin
            frame_buf[row_ptr*COLS +: COLS] <= ~col_sync;   // Invert, 1 = pressed
        end
    end

    // Row 3 completes the frame, whole matrix published at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_matrix <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (row_end && (row_ptr == PTR_W'(ROWS - 1))) begin
                key_matrix <= {~col_sync, frame_buf};
                frame_done <= 1'b1;        // Visible the cycle after the write
            end
        end
    end

endmodule

/* source/key_debouncer.sv */
module key_debouncer
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] key_matrix,        // Stable between frame_done strobes
    input  logic        frame_done,
    input  logic        key_ack,           // From display
    output logic        key_req,           // Four-phase request
    output logic [3:0]  key_code           // Hex code, held while key_req
);

    localparam int CNT_W = $clog2(DEBOUNCE_FRAMES + 1);

    typedef enum logic [1:0] {
        HS_IDLE,                           // Free to raise a request
        HS_REQ,                            // key_req high, waiting for ack
        HS_RELEASE                         // key_req dropped, waiting ack low
    } hs_state_t;

    hs_state_t        hs_state;
    logic [CNT_W-1:0] match_cnt;           // Consecutive frames of last_idx
    logic [CNT_W-1:0] match_next;
    logic [3:0]       last_idx;            // Key seen in previous frame
    logic [3:0]       key_idx;             // Encoded index of current frame
    logic             frame_empty;
    logic             single_key;
    logic             reported;            // Current press already sent
    logic             threshold;           // This frame completes the run

    // ========================================================================
    // Frame classification
    // ========================================================================
    assign frame_empty = (key_matrix == '0);
    // Clearing the lowest set bit leaves zero only for a lone key
    assign single_key  = !frame_empty && ((key_matrix & (key_matrix - 16'd1)) == '0);

    // Index of the set bit, meaningful only when single_key
    always_comb begin
        key_idx = '0;
        for (int i = 0; i < ROWS*COLS; i++) begin
            if (key_matrix[i]) begin
                key_idx = 4'(i);
            end
        end
    end

    // Run length including this frame, saturates at the threshold
    always_comb begin
        if ((key_idx == last_idx) && (match_cnt != '0)) begin
            if (match_cnt == CNT_W'(DEBOUNCE_FRAMES)) match_next = match_cnt;
            else match_next = match_cnt + 1'b1;
        end else begin
            match_next = CNT_W'(1);        // First frame of a new run
        end
    end

    assign threshold = frame_done && single_key && !reported &&
                       (match_next == CNT_W'(DEBOUNCE_FRAMES));

    // ========================================================================
    // Run tracking
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match_cnt <= '0;
            last_idx  <= '0;
            reported  <= 1'b0;
        end else if (frame_done) begin
            if (frame_empty) begin
                match_cnt <= '0;           // Full release re-arms
                reported  <= 1'b0;
            end else if (!single_key) begin
                match_cnt <= '0;           // Ghosting risk, drop the frame
            end else begin
                match_cnt <= match_next;
                last_idx  <= key_idx;
                if (threshold) reported <= 1'b1;   // Also when dropped under back-pressure
            end
        end
    end

    // ========================================================================
    // Request side of the handshake
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state <= HS_IDLE;
        end else begin
            case (hs_state)
                HS_IDLE:    if (threshold && !key_ack) hs_state <= HS_REQ;
                HS_REQ:     if (key_ack) hs_state <= HS_RELEASE;
                HS_RELEASE: if (!key_ack) hs_state <= HS_IDLE;
                default:    hs_state <= HS_IDLE;
            endcase
        end
    end

    // Code loads only when a request opens
    always_ff @(posedge clk) begin
        if ((hs_state == HS_IDLE) && threshold && !key_ack) begin
            key_code <= KEY_LAYOUT[key_idx];
        end
    end

    assign key_req = (hs_state == HS_REQ);

endmodule

/* source/digit_display.sv */
module digit_display
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_req,            // From debouncer
    input  logic [3:0] key_code,
    output logic       key_ack,
    output logic [6:0] seg,                // gfedcba, active low
    output logic [1:0] an                  // Digit enables, active low
);

    localparam int MUX_W = $clog2(DIGIT_PERIOD);

    logic [3:0]       code_right;          // Newest key
    logic [3:0]       code_left;           // Key before it
    logic             valid_right;
    logic             valid_left;
    logic             take_code;           // Handshake accept cycle
    logic [MUX_W-1:0] mux_cnt;
    logic             digit_sel;           // 0 = right digit, 1 = left digit

    // ========================================================================
    // Acknowledge side
    // ========================================================================
    // key_ack follows key_req one cycle late, in both directions
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_ack <= 1'b0;
        end else begin
            key_ack <= key_req;
        end
    end

    assign take_code = key_req && !key_ack;   // Same edge that raises key_ack

    // ========================================================================
    // Two-digit history
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_right <= 1'b0;           // Both blank until keys arrive
            valid_left  <= 1'b0;
        end else if (take_code) begin
            valid_right <= 1'b1;
            valid_left  <= valid_right;
        end
    end

    always_ff @(posedge clk) begin
        if (take_code) begin
            code_left  <= code_right;      // Shift left
            code_right <= key_code;
        end
    end

    // ========================================================================
    // Digit multiplexing
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mux_cnt   <= '0;
            digit_sel <= 1'b0;             // Right digit first
        end else if (mux_cnt == MUX_W'(DIGIT_PERIOD - 1)) begin
            mux_cnt   <= '0;
            digit_sel <= ~digit_sel;
        end else begin
            mux_cnt <= mux_cnt + 1'b1;
        end
    end

    assign an = digit_sel ? 2'b01 : 2'b10;

    // Segment pattern for whichever digit is lit
    always_comb begin
        if (digit_sel) begin
            seg = valid_left ? seg_of(code_left) : SEG_BLANK;
        end else begin
            seg = valid_right ? seg_of(code_right) : SEG_BLANK;
        end
    end

endmodule

/* source/keypad_display_top.sv */
module keypad_display_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] col,                // Keypad columns, pulled up
    output logic [3:0] row,                // Keypad rows, active low
    output logic [6:0] seg,                // Shared segment lines, active low
    output logic [1:0] an                  // Digit enables, active low
);

    // ========================================================================
    // Internal nets
    // ========================================================================
    logic [15:0] key_matrix;               // Scanner -> debouncer
    logic        frame_done;
    logic        key_req;                  // Debouncer <-> display handshake
    logic        key_ack;
    logic [3:0]  key_code;

    keypad_scanner scanner_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .col        (col),
        .row        (row),
        .key_matrix (key_matrix),
        .frame_done (frame_done)
    );

    // Accepts one clean key per press
    key_debouncer debounce_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_matrix (key_matrix),
        .frame_done (frame_done),
        .key_ack    (key_ack),
        .key_req    (key_req),
        .key_code   (key_code)
    );

    digit_display display_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_req  (key_req),
        .key_code (key_code),
        .key_ack  (key_ack),
        .seg      (seg),
        .an       (an)
    );

endmodule

/* sim/keypad_assert.sv */
module keypad_assert (
    input logic       clk,
    input logic       rst_n,
    input logic [3:0] row,                 // Keypad rows, active low
    input logic       key_req,             // Debouncer request
    input logic       key_ack,             // Display acknowledge
    input logic [3:0] key_code
);
    timeunit 1ns;
    timeprecision 1ps;

    // ========================================================================
    // Row driving
    // ========================================================================
    // Exactly one row pulled low, never two shorted together
    one_row_low: assert property (
        @(posedge clk) disable iff (!rst_n) $countones(~row) == 1
    ) else $error("row drives %b, not a single low line", row);

    // ========================================================================
    // Four-phase handshake
    // ========================================================================
    // Request and code held until the acknowledge shows up
    req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        key_req && !key_ack |=> key_req && $stable(key_code)
    ) else $error("key_req or key_code changed before key_ack");

    // No acknowledge without a request
    ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        !key_req && !key_ack |=> !key_ack
    ) else $error("key_ack rose while key_req was low");

endmodule

bind keypad_display_top keypad_assert assert_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .row      (row),
    .key_req  (key_req),
    .key_ack  (key_ack),
    .key_code (key_code)
);

/* sim/tb_keypad_display.sv */
module tb_keypad_display
    import keypad_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF     = 4;                   // 8 ns period
    localparam int FRAME_CYCLES = ROWS * SCAN_PERIOD;  // One full scan
    localparam int WAIT_FRAMES  = 6;                   // Bound on display update
    localparam int GAP_FRAMES   = 2;                   // Idle after release re-arms
    // Scan 8, single 13, history 4 x 13, bounce 10, multi/hold 14 + 20 + 13
    localparam int BUDGET_FRAMES = 8 + 13 + 4 * 13 + 10 + 47;
    localparam int WATCHDOG_NS   = BUDGET_FRAMES * FRAME_CYCLES * 2 * CLK_HALF + 4000;

    // Expected row order, one line low
    localparam logic [3:0] ROW_SEQ [0:3] = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};

    logic        clk;
    logic        rst_n;
    logic [3:0]  col;
    logic [3:0]  row;
    logic [6:0]  seg;
    logic [1:0]  an;
    logic [15:0] pressed;                  // Held keys, bit = key index
    logic [31:0] lfsr_state = 32'hd9b3_ede5;
    logic [6:0]  exp_right = SEG_BLANK;    // Display model
    logic [6:0]  exp_left  = SEG_BLANK;
    int          value_errors = 0;
    int          other_errors = 0;

    keypad_display_top uut (
        .clk   (clk),
        .rst_n (rst_n),
        .col   (col),
        .row   (row),
        .seg   (seg),
        .an    (an)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // ========================================================================
    // Keypad matrix model
    // ========================================================================
    // Closed switch shorts its column to the driven row
    always_comb begin
        col = '1;                          // Pull-ups
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                if (pressed[4'(r * COLS + c)] && !row[2'(r)]) col[2'(c)] = 1'b0;
            end
        end
    end

    // ========================================================================
    // Helpers and checks
    // ========================================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) return (state >> 1) ^ 32'h8020_0003;   // Taps 32, 22, 2, 1
        else return state >> 1;
    endfunction

    task automatic random_key(output logic [3:0] idx);
        idx = '0;
        for (int b = 0; b < 4; b++) begin
            idx        = {idx[2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);              // One step per bit
        end
    endtask

    task automatic compare_row(input string name, input logic [3:0] expected,
                               input logic [3:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic compare_seg(input string name, input logic [6:0] expected,
                               input logic [6:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic compare_an(input string name, input logic [1:0] expected,
                              input logic [1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    // Hold a key mask, release, then let the debouncer see empty frames
    task automatic press_keys(input logic [15:0] mask, input int frames);
        @(posedge clk);
        pressed <= mask;
        repeat (frames * FRAME_CYCLES) @(posedge clk);
        pressed <= '0;
        repeat (GAP_FRAMES * FRAME_CYCLES) @(posedge clk);
    endtask

    // Newest key to the right, old right moves left
    task automatic note_key(input logic [3:0] idx);
        exp_left  = exp_right;
        exp_right = seg_of(KEY_LAYOUT[idx]);
    endtask

    // Sample seg under each enable until both digits match or time runs out
    task automatic wait_digits(input string name, input logic [6:0] want_right,
                               input logic [6:0] want_left);
        logic [6:0] got_right;
        logic [6:0] got_left;
        bit         have_right;
        bit         have_left;
        bit         done;
        got_right  = '1;
        got_left   = '1;
        have_right = 0;
        have_left  = 0;
        done       = 0;
        for (int i = 0; i < WAIT_FRAMES * FRAME_CYCLES && !done; i++) begin
            @(negedge clk);                // Outputs settled by mid-cycle
            if (an == 2'b10) begin
                got_right  = seg;
                have_right = 1;
            end else if (an == 2'b01) begin
                got_left  = seg;
                have_left = 1;
            end
            done = have_right && have_left && got_right == want_right
                   && got_left == want_left;
        end
        if (!have_right || !have_left) begin
            $display("%s: the display never enabled both digits", name);
            other_errors++;
        end else begin
            compare_seg({name, " right"}, want_right, got_right);
            compare_seg({name, " left"}, want_left, got_left);
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================
    // Rows 0 to 3 and back to 0, plus the digit enables, cycle by cycle
    task automatic reset_and_scan();
        logic [3:0] want_row;
        logic [1:0] want_an;
        for (int n = 0; n < (ROWS + 1) * SCAN_PERIOD; n++) begin
            @(negedge clk);                // Cycle n after reset release
            want_row = ROW_SEQ[2'((n / SCAN_PERIOD) % ROWS)];
            want_an  = ((n / DIGIT_PERIOD) % 2 == 0) ? 2'b10 : 2'b01;   // Right digit first
            compare_row($sformatf("scan_order cycle %0d", n), want_row, row);
            compare_an($sformatf("digit_enable cycle %0d", n), want_an, an);
        end
        wait_digits("reset_blank", SEG_BLANK, SEG_BLANK);
    endtask

    task automatic single_press();
        press_keys(16'b1 << 9, 5);         // Row 2 col 1
        note_key(4'd9);
        wait_digits("single_press", exp_right, exp_left);
    endtask

    task automatic history_shift();
        logic [3:0] idx;
        for (int n = 0; n < 4; n++) begin
            random_key(idx);
            press_keys(16'b1 << idx, 5);
            note_key(idx);
            wait_digits($sformatf("history_shift_%0d", n), exp_right, exp_left);
        end
    endtask

    task automatic bounce_rejection();
        press_keys(16'b1 << 0, 2);         // One short of acceptance
        wait_digits("bounce", exp_right, exp_left);
    endtask

    task automatic multi_key_and_hold();
        press_keys(16'h0060, 6);           // Keys 5 and 6 share row 1
        wait_digits("multi_key", exp_right, exp_left);
        press_keys(16'b1 << 14, 12);       // Long hold reports once
        note_key(4'd14);
        wait_digits("long_hold", exp_right, exp_left);
        press_keys(16'b1 << 14, 5);        // Fresh press of the same key
        note_key(4'd14);
        wait_digits("repress", exp_right, exp_left);
    endtask

    // ========================================================================
    // Run control
    // ========================================================================
    task automatic finish_run();
        $display("Checks done: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    initial begin
        rst_n   = 1'b0;
        pressed = '0;                      // Keypad idle
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_and_scan();
        single_press();
        history_shift();
        bounce_rejection();
        multi_key_and_hold();
        finish_run();
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        other_errors++;
        finish_run();
    end

endmodule

/* sim.f */
source/keypad_pkg.sv
source/keypad_scanner.sv
source/key_debouncer.sv
source/digit_display.sv
source/keypad_display_top.sv
sim/keypad_assert.sv
sim/tb_keypad_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the keypad display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_keypad_display \
    -f sim.f

# A failed assertion may stop the run early, the search below decides
output=$(./obj_dir/Vtb_keypad_display 2>&1) || true
echo "$output"

if grep -qx "SIMULATION PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
